// ==== files.f ====
+incdir+verilog
verilog/spi_pkg.sv
verilog/spi_ctrl_if.sv
verilog/spi_regs.sv
verilog/spi_engine.sv
verilog/spi_top.sv
test/spi_slave_model.sv
test/tb_spi_top.sv

// ==== Makefile ====
# Verilator build and run for the SPI master testbench
# Any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_spi_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= \*\*\* TEST PASSED \*\*\*

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Simulation status comes from the log, not the exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_STR)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_spi_top.sv ====
`include "spi_cfg.svh"

module tb_spi_top
  import spi_pkg::*;
;

  localparam int POLL_LIMIT = 1000;
  localparam int SS_LIMIT   = 20;

  logic                   clk;
  logic                   reset_n;
  logic                   bus_cs;
  logic                   bus_we;
  logic [`SPI_ADDR_W-1:0] bus_addr;
  logic [`SPI_DATA_W-1:0] bus_wdata;
  logic [`SPI_DATA_W-1:0] bus_rdata;
  logic                   spi_ss;
  logic                   spi_sck;
  logic                   spi_mosi;
  logic                   spi_miso;

  // Slave side
  logic [7:0] reply_byte;
  logic [7:0] captured_byte;
  int         rise_count;

  // LFSR state and reference model
  logic [31:0] lfsr;
  logic        model_enable;
  logic [7:0]  model_tx;
  int          errors;
  int          checks;
  int          tests;
  int          test_errors;

  spi_top u_spi_top (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_cs    (bus_cs),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .spi_ss    (spi_ss),
    .spi_sck   (spi_sck),
    .spi_mosi  (spi_mosi),
    .spi_miso  (spi_miso)
  );

  spi_slave_model u_slave (
    .spi_ss        (spi_ss),
    .spi_sck       (spi_sck),
    .spi_mosi      (spi_mosi),
    .spi_miso      (spi_miso),
    .reply_byte    (reply_byte),
    .captured_byte (captured_byte),
    .rise_count    (rise_count)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  task automatic random_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t waiting for %s", $time, what);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("Test %0d (%s) done with %0d errors", tests, name, test_errors);
    test_errors = 0;
  endtask

  // Bus tasks, entered and left on a falling edge
  task automatic bus_write(input logic [`SPI_ADDR_W-1:0] addr,
                           input logic [`SPI_DATA_W-1:0] data);
    bus_cs    = 1'b1;
    bus_we    = 1'b1;
    bus_addr  = addr;
    bus_wdata = data;
    @(negedge clk);
    bus_cs    = 1'b0;
    bus_we    = 1'b0;
  endtask

  // Registered read data is stable by the next falling edge
  task automatic bus_read(input logic [`SPI_ADDR_W-1:0] addr,
                          output logic [`SPI_DATA_W-1:0] data);
    bus_cs   = 1'b1;
    bus_we   = 1'b0;
    bus_addr = addr;
    @(negedge clk);
    bus_cs   = 1'b0;
    data     = bus_rdata;
  endtask

  // Poll status bit 0 until it matches
  task automatic wait_ready(input logic level);
    logic [7:0] status;
    int         polls;
    polls = 0;
    bus_read(ADDR_CTRL, status);
    while (status[0] != level && polls < POLL_LIMIT) begin
      bus_read(ADDR_CTRL, status);
      polls++;
    end
    if (status[0] != level) begin
      report_timeout(level ? "ready to rise" : "ready to fall");
    end
  endtask

  task automatic set_enable(input logic en);
    int polls;
    polls = 0;
    bus_write(ADDR_CTRL, `SPI_DATA_W'(en));
    model_enable = en;
    // Chip select pin lags the write by two cycles
    while (spi_ss != !en && polls < SS_LIMIT) begin
      @(negedge clk);
      polls++;
    end
    if (spi_ss != !en) begin
      report_timeout("chip select to change");
    end
  endtask

  task automatic check_status();
    logic [7:0] status;
    bus_read(ADDR_CTRL, status);
    check_value("status", 32'(status), 32'({6'b0, model_enable, 1'b1}));
  endtask

  // One byte exchange, optionally poking TXDATA and start mid-transfer
  task automatic run_transfer(input logic [7:0] tx, input logic [7:0] reply,
                              input logic poke_busy);
    int         rises_before;
    logic [7:0] other;
    logic [7:0] rx;
    reply_byte   = reply;
    rises_before = rise_count;
    bus_write(ADDR_TXDATA, tx);
    model_tx = tx;
    bus_write(ADDR_CTRL, 8'h03);
    wait_ready(1'b0);
    if (poke_busy) begin
      random_byte(other);
      bus_write(ADDR_TXDATA, other);
      model_tx = other;
      bus_write(ADDR_CTRL, 8'h03);
    end
    wait_ready(1'b1);
    check_value("slave MOSI byte", 32'(captured_byte), 32'(tx));
    check_value("SCK rising edges", rise_count - rises_before, 8);
    check_value("SCK level after byte", 32'(spi_sck), 0);
    bus_read(ADDR_RXDATA, rx);
    check_value("RXDATA", 32'(rx), 32'(reply));
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [7:0] rd;
    logic [7:0] tx;
    logic [7:0] reply;
    int         rises;
    bus_cs       = 1'b0;
    bus_we       = 1'b0;
    bus_addr     = '0;
    bus_wdata    = '0;
    reply_byte   = 8'h00;
    lfsr         = 32'h959f;
    model_enable = 1'b0;
    model_tx     = 8'h00;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    test_errors  = 0;
    reset_n      = 1'b0;
    repeat (5) @(negedge clk);
    reset_n = 1'b1;

    // Idle state out of reset
    check_value("bus_rdata after reset", 32'(bus_rdata), 0);
    check_value("spi_ss after reset", 32'(spi_ss), 1);
    check_value("spi_sck after reset", 32'(spi_sck), 0);
    check_status();
    bus_read(ADDR_RXDATA, rd);
    check_value("RXDATA after reset", 32'(rd), 0);
    finish_test("reset state");

    // Software chip select
    set_enable(1'b1);
    check_status();
    set_enable(1'b0);
    check_status();
    finish_test("chip select");

    // One frame of random bytes with SS held low
    set_enable(1'b1);
    for (int n = 0; n < 20; n++) begin
      random_byte(tx);
      random_byte(reply);
      run_transfer(tx, reply, 1'b0);
    end
    check_status();
    set_enable(1'b0);
    finish_test("random transfers");

    // Commands while busy are dropped
    set_enable(1'b1);
    random_byte(tx);
    random_byte(reply);
    run_transfer(tx, reply, 1'b1);
    rises = rise_count;
    repeat (100) @(negedge clk);
    check_value("SCK edges after busy start", rise_count, rises);
    bus_read(ADDR_TXDATA, rd);
    check_value("TXDATA readback", 32'(rd), 32'(model_tx));
    check_status();
    set_enable(1'b0);
    finish_test("busy commands");

    // Unmapped slot and transmit readback
    bus_read(2'd3, rd);
    check_value("unmapped address", 32'(rd), 0);
    random_byte(tx);
    bus_write(ADDR_TXDATA, tx);
    model_tx = tx;
    bus_read(ADDR_TXDATA, rd);
    check_value("TXDATA readback", 32'(rd), 32'(model_tx));
    finish_test("register readback");

    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== test/spi_slave_model.sv ====
module spi_slave_model (
  input  logic       spi_ss,
  input  logic       spi_sck,
  input  logic       spi_mosi,
  output logic       spi_miso,
  // Byte returned to the master, set before each transfer
  input  logic [7:0] reply_byte,
  // Last eight MOSI bits seen, MSB first
  output logic [7:0] captured_byte,
  output int         rise_count
);

  // ----------------------------------------
  // Slave state
  // ----------------------------------------
  // Bit of reply_byte driven next, wraps every byte
  logic [2:0] bit_idx = 3'd7;

  initial begin
    spi_miso      = 1'b0;
    captured_byte = 8'h00;
    rise_count    = 0;
  end

  // Mode 0 slave, sample and drive on the rising SCK
  always @(posedge spi_sck) begin
    if (!spi_ss) begin
      captured_byte <= {captured_byte[6:0], spi_mosi};
      // First rise of a byte presents bit 7
      spi_miso      <= reply_byte[bit_idx];
      bit_idx       <= bit_idx - 3'd1;
      rise_count    <= rise_count + 1;
    end
  end

endmodule

// ==== verilog/spi_top.sv ====
`include "spi_cfg.svh"

module spi_top (
  input  logic                   clk,
  input  logic                   reset_n,

  // Host bus
  input  logic                   bus_cs,
  input  logic                   bus_we,
  input  logic [`SPI_ADDR_W-1:0] bus_addr,
  input  logic [`SPI_DATA_W-1:0] bus_wdata,
  output logic [`SPI_DATA_W-1:0] bus_rdata,

  // SPI pins
  output logic                   spi_ss,
  output logic                   spi_sck,
  output logic                   spi_mosi,
  input  logic                   spi_miso
);

  // Command and status link
  spi_ctrl_if ctrl_if ();

  spi_regs u_regs (
    .clk       (clk),
    .reset_n   (reset_n),
    .bus_cs    (bus_cs),
    .bus_we    (bus_we),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .ctrl      (ctrl_if.regs)
  );

  spi_engine u_engine (
    .clk      (clk),
    .reset_n  (reset_n),
    .ctrl     (ctrl_if.engine),
    .spi_ss   (spi_ss),
    .spi_sck  (spi_sck),
    .spi_mosi (spi_mosi),
    .spi_miso (spi_miso)
  );

endmodule

// ==== verilog/spi_engine.sv ====
`include "spi_cfg.svh"

module spi_engine (
  input  logic       clk,
  input  logic       reset_n,
  spi_ctrl_if.engine ctrl,
  output logic       spi_ss,
  output logic       spi_sck,
  output logic       spi_mosi,
  input  logic       spi_miso
);

  // ----------------------------------------
  // Constants
  // ----------------------------------------
  localparam logic [2:0] ST_IDLE      = 3'd0;
  localparam logic [2:0] ST_POS_EDGE  = 3'd1;
  localparam logic [2:0] ST_HIGH_WAIT = 3'd2;
  localparam logic [2:0] ST_NEG_EDGE  = 3'd3;
  localparam logic [2:0] ST_LOW_WAIT  = 3'd4;
  localparam logic [2:0] ST_NEXT_BIT  = 3'd5;

  // Half-period counter width covers SPI_HALF_CYCLES
  localparam int CTR_W = $clog2(`SPI_HALF_CYCLES + 1);
  localparam logic [CTR_W-1:0] CTR_LAST = CTR_W'(`SPI_HALF_CYCLES - 1);
  localparam logic [2:0] BIT_LAST = 3'(`SPI_DATA_W - 1);

  // ----------------------------------------
  // State
  // ----------------------------------------
  logic [2:0]             state;
  logic [2:0]             state_nxt;
  logic                   ss_reg;
  logic                   sck_reg;
  logic [`SPI_DATA_W-1:0] tx_reg;
  logic [`SPI_DATA_W-1:0] rx_reg;
  logic [CTR_W-1:0]       half_ctr;
  logic [2:0]             bit_ctr;
  logic                   ready_reg;
  logic                   miso_meta;
  logic                   miso_sync;

  // FSM action flags
  logic sck_set;
  logic sck_clr;
  logic ctr_clr;
  logic bit_clr;
  logic bit_inc;
  logic shift;
  logic rx_clr;
  logic ready_set;
  logic ready_clr;

  // Two-flop MISO synchronizer
  always_ff @(posedge clk) begin
    miso_meta <= spi_miso;
    miso_sync <= miso_meta;
  end

  // ----------------------------------------
  // Controller
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    sck_set   = 1'b0;
    sck_clr   = 1'b0;
    ctr_clr   = 1'b0;
    bit_clr   = 1'b0;
    bit_inc   = 1'b0;
    shift     = 1'b0;
    rx_clr    = 1'b0;
    ready_set = 1'b0;
    ready_clr = 1'b0;
    case (state)
      ST_IDLE: begin
        // Start honoured only here
        if (ctrl.start) begin
          rx_clr    = 1'b1;
          bit_clr   = 1'b1;
          ready_clr = 1'b1;
          state_nxt = ST_POS_EDGE;
        end
      end
      ST_POS_EDGE: begin
        sck_set   = 1'b1;
        ctr_clr   = 1'b1;
        state_nxt = ST_HIGH_WAIT;
      end
      ST_HIGH_WAIT: begin
        if (half_ctr == CTR_LAST) begin
          state_nxt = ST_NEG_EDGE;
        end
      end
      ST_NEG_EDGE: begin
        sck_clr   = 1'b1;
        ctr_clr   = 1'b1;
        state_nxt = ST_LOW_WAIT;
      end
      ST_LOW_WAIT: begin
        // Sample settled MISO and shift at the end of the low hold
        if (half_ctr == CTR_LAST) begin
          shift     = 1'b1;
          state_nxt = ST_NEXT_BIT;
        end
      end
      ST_NEXT_BIT: begin
        if (bit_ctr == BIT_LAST) begin
          ready_set = 1'b1;
          state_nxt = ST_IDLE;
        end else begin
          bit_inc   = 1'b1;
          state_nxt = ST_POS_EDGE;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // Register update
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state     <= ST_IDLE;
      ss_reg    <= 1'b1;
      sck_reg   <= 1'b0;
      tx_reg    <= '0;
      rx_reg    <= '0;
      half_ctr  <= '0;
      bit_ctr   <= '0;
      ready_reg <= 1'b1;
    end else begin
      state    <= state_nxt;
      half_ctr <= ctr_clr ? '0 : half_ctr + 1'b1;

      // Chip select follows software
      if (ctrl.enable_vld) begin
        ss_reg <= ~ctrl.enable;
      end

      if (sck_set) begin
        sck_reg <= 1'b1;
      end else if (sck_clr) begin
        sck_reg <= 1'b0;
      end

      // New byte loads only while idle and shifts out MSB first
      if (ctrl.tx_vld && ready_reg) begin
        tx_reg <= ctrl.tx_data;
      end else if (shift) begin
        tx_reg <= {tx_reg[`SPI_DATA_W-2:0], 1'b0};
      end

      if (rx_clr) begin
        rx_reg <= '0;
      end else if (shift) begin
        rx_reg <= {rx_reg[`SPI_DATA_W-2:0], miso_sync};
      end

      if (bit_clr) begin
        bit_ctr <= '0;
      end else if (bit_inc) begin
        bit_ctr <= bit_ctr + 3'd1;
      end

      if (ready_clr) begin
        ready_reg <= 1'b0;
      end else if (ready_set) begin
        ready_reg <= 1'b1;
      end
    end
  end

  // Pins and status
  assign spi_ss       = ss_reg;
  assign spi_sck      = sck_reg;
  assign spi_mosi     = tx_reg[`SPI_DATA_W-1];
  assign ctrl.rx_data = rx_reg;
  assign ctrl.ready   = ready_reg;

endmodule

// ==== verilog/spi_regs.sv ====
`include "spi_cfg.svh"

module spi_regs
  import spi_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   bus_cs,
  input  logic                   bus_we,
  input  logic [`SPI_ADDR_W-1:0] bus_addr,
  input  spi_wdata_u             bus_wdata,
  output logic [`SPI_DATA_W-1:0] bus_rdata,
  spi_ctrl_if.regs               ctrl
);

  // ----------------------------------------
  // Access decode
  // ----------------------------------------
  logic wr_ctrl;
  logic wr_tx;
  logic rd_en;

  // Control state
  logic enable_reg;
  logic enable_vld_reg;
  logic start_reg;
  logic tx_vld_reg;

  // Payload and read path
  logic [`SPI_DATA_W-1:0] tx_data_reg;
  logic [`SPI_DATA_W-1:0] rdata_reg;
  logic [`SPI_DATA_W-1:0] read_word;

  assign wr_ctrl = bus_cs && bus_we && (bus_addr == ADDR_CTRL);
  assign wr_tx   = bus_cs && bus_we && (bus_addr == ADDR_TXDATA);
  // Any non-write access is a read
  assign rd_en   = bus_cs && !bus_we;

  // ----------------------------------------
  // Command strobes and levels
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      enable_reg     <= 1'b0;
      enable_vld_reg <= 1'b0;
      start_reg      <= 1'b0;
      tx_vld_reg     <= 1'b0;
      rdata_reg      <= '0;
    end else begin
      // Strobes live for exactly one cycle
      enable_vld_reg <= wr_ctrl;
      start_reg      <= wr_ctrl && bus_wdata.ctrl.start;
      tx_vld_reg     <= wr_tx;
      if (wr_ctrl) begin
        enable_reg <= bus_wdata.ctrl.enable;
      end
      // Read data held until the next read
      if (rd_en) begin
        rdata_reg <= read_word;
      end
    end
  end

  // Last byte written, also the readback value
  always_ff @(posedge clk) begin
    if (wr_tx) begin
      tx_data_reg <= bus_wdata.tx_byte;
    end
  end

  // ----------------------------------------
  // Read mux
  // ----------------------------------------
  always_comb begin
    read_word = '0;
    case (spi_addr_e'(bus_addr))
      ADDR_CTRL: begin
        // Status: ready, chip select active
        read_word[0] = ctrl.ready;
        read_word[1] = enable_reg;
      end
      ADDR_TXDATA: begin
        read_word = tx_data_reg;
      end
      ADDR_RXDATA: begin
        read_word = ctrl.rx_data;
      end
      default: begin
        read_word = '0;
      end
    endcase
  end

  // Engine side
  assign ctrl.enable     = enable_reg;
  assign ctrl.enable_vld = enable_vld_reg;
  assign ctrl.start      = start_reg;
  assign ctrl.tx_data    = tx_data_reg;
  assign ctrl.tx_vld     = tx_vld_reg;

  assign bus_rdata = rdata_reg;

endmodule

// ==== verilog/spi_ctrl_if.sv ====
`include "spi_cfg.svh"

interface spi_ctrl_if;

  // Commands from the register block
  logic                   enable;
  logic                   enable_vld;
  logic                   start;
  logic [`SPI_DATA_W-1:0] tx_data;
  logic                   tx_vld;

  // Status back from the engine
  logic [`SPI_DATA_W-1:0] rx_data;
  logic                   ready;

  modport regs (
    output enable, enable_vld, start, tx_data, tx_vld,
    input  rx_data, ready
  );

  modport engine (
    input  enable, enable_vld, start, tx_data, tx_vld,
    output rx_data, ready
  );

endinterface

// ==== verilog/spi_pkg.sv ====
`include "spi_cfg.svh"

package spi_pkg;

  // Register map
  // Address 3 left unmapped, reads as zero
  typedef enum logic [`SPI_ADDR_W-1:0] {
    ADDR_CTRL   = `SPI_ADDR_W'(0),
    ADDR_TXDATA = `SPI_ADDR_W'(1),
    ADDR_RXDATA = `SPI_ADDR_W'(2)
  } spi_addr_e;

  // Bus write word
  // CTRL slot sees the control bits, TXDATA slot sees a raw byte
  typedef union packed {
    struct packed {
      logic [`SPI_DATA_W-3:0] reserved;
      logic                   start;
      logic                   enable;
    } ctrl;
    logic [`SPI_DATA_W-1:0] tx_byte;
  } spi_wdata_u;

endpackage

// ==== verilog/spi_cfg.svh ====
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// ----------------------------------------
// Bus geometry
// ----------------------------------------
// Host bus address width, four word slots
`define SPI_ADDR_W 2
// Bus word and SPI byte share one width
`define SPI_DATA_W 8

// ----------------------------------------
// Serial clock timing
// ----------------------------------------
// clk cycles each SCK level is held
`define SPI_HALF_CYCLES 16

`endif
